/* hw/gpr_pkg.sv */
`default_nettype none

package gpr_pkg;

    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NUM_REGS     = 32;
    localparam int XLEN         = 32;
    localparam int RAM_SIZE     = NUM_WARPS * NUM_REGS;
    localparam int RAM_ADDRW    = $clog2(RAM_SIZE);
    localparam int NUM_RD_PORTS = 3;
    localparam int RSP_LATENCY  = 2;     // Request edge to response edge

    typedef logic [$clog2(NUM_WARPS)-1:0] wid_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [NUM_THREADS-1:0]       tmask_t;
    typedef logic [XLEN-1:0]              word_t;
    typedef logic [RAM_ADDRW-1:0]         ram_addr_t;   // {wid, reg}

    // Writeback from the execute side
    typedef struct packed {
        logic                         valid;
        wid_t                         wid;
        reg_idx_t                     rd;
        tmask_t                       tmask;
        word_t [NUM_THREADS-1:0]      data;
    } wb_req_t;

    // Operand read request from issue
    typedef struct packed {
        logic                         valid;
        wid_t                         wid;
        tmask_t                       tmask;
        reg_idx_t                     rs1;
        reg_idx_t                     rs2;
        reg_idx_t                     rs3;
    } gpr_req_t;

    typedef struct packed {
        logic                         valid;
        wid_t                         wid;
        tmask_t                       tmask;
        word_t [NUM_THREADS-1:0]      rs1_data;
        word_t [NUM_THREADS-1:0]      rs2_data;
        word_t [NUM_THREADS-1:0]      rs3_data;
    } gpr_rsp_t;

    // Index 0 is rs1, 1 is rs2, 2 is rs3
    typedef struct packed {
        ram_addr_t [NUM_RD_PORTS-1:0] addr;
        logic [NUM_RD_PORTS-1:0]      fwd;    // Write hits this read address
    } rd_addr_t;

endpackage

`default_nettype wire

/* hw/gpr_dp_ram.sv */
`default_nettype none

module gpr_dp_ram #(
    parameter int DATAW = 32,
    parameter int SIZE  = 128
) (
    input  logic                     clk,
    input  logic                     write,
    input  logic [$clog2(SIZE)-1:0]  waddr,
    input  logic [DATAW-1:0]         wdata,
    input  logic [$clog2(SIZE)-1:0]  raddr,
    output logic [DATAW-1:0]         rdata
);

    logic [DATAW-1:0] mem [SIZE];

    // Register file starts out all zero
    initial begin
        for (int i = 0; i < SIZE; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // Old contents on a collision
    end

endmodule

`default_nettype wire

/* hw/gpr_port_map.sv */
`default_nettype none

module gpr_port_map
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wb_req_t   wb,
    input  gpr_req_t  req,
    output ram_addr_t waddr,
    output tmask_t    lane_we,
    output rd_addr_t  rd_addr,
    output logic      meta_valid,
    output wid_t      meta_wid,
    output tmask_t    meta_tmask
);

    logic      wr_en;
    ram_addr_t raddr [NUM_RD_PORTS];

    // r0 is hardwired to zero
    assign wr_en   = wb.valid && (wb.rd != '0);
    assign waddr   = {wb.wid, wb.rd};
    assign lane_we = {NUM_THREADS{wr_en}} & wb.tmask;

    assign raddr[0] = {req.wid, req.rs1};
    assign raddr[1] = {req.wid, req.rs2};
    assign raddr[2] = {req.wid, req.rs3};

    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rd_addr.addr[p] = raddr[p];
            rd_addr.fwd[p]  = wr_en && (waddr == raddr[p]);   // Lane adds its own mask bit
        end
    end

    // Metadata travels alongside the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            meta_valid <= 1'b0;
            meta_wid   <= '0;
            meta_tmask <= '0;
        end else begin
            meta_valid <= req.valid;
            meta_wid   <= req.wid;
            meta_tmask <= req.valid ? req.tmask : '0;
        end
    end

endmodule

`default_nettype wire

/* hw/gpr_lane.sv */
`default_nettype none

module gpr_lane
    import gpr_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  ram_addr_t waddr,
    input  word_t     wdata,
    input  rd_addr_t  rd_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     rs3_data
);

    word_t                   ram_rdata [NUM_RD_PORTS];
    word_t                   operand   [NUM_RD_PORTS];
    word_t                   wdata_q;
    logic [NUM_RD_PORTS-1:0] fwd_sel_q;

    // One copy of the register file per read port
    for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_port
        gpr_dp_ram #(
            .DATAW (XLEN),
            .SIZE  (RAM_SIZE)
        ) ram0 (
            .clk   (clk),
            .write (we),
            .waddr (waddr),
            .wdata (wdata),
            .raddr (rd_addr.addr[p]),
            .rdata (ram_rdata[p])
        );

        assign operand[p] = fwd_sel_q[p] ? wdata_q : ram_rdata[p];
    end

    always_ff @(posedge clk) begin
        wdata_q   <= wdata;
        fwd_sel_q <= rd_addr.fwd & {NUM_RD_PORTS{we}};
    end

    assign rs1_data = operand[0];
    assign rs2_data = operand[1];
    assign rs3_data = operand[2];

endmodule

`default_nettype wire

/* hw/gpr_operand_collect.sv */
`default_nettype none

module gpr_operand_collect
    import gpr_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    meta_valid,
    input  wid_t                    meta_wid,
    input  tmask_t                  meta_tmask,
    input  word_t [NUM_THREADS-1:0] lane_rs1,
    input  word_t [NUM_THREADS-1:0] lane_rs2,
    input  word_t [NUM_THREADS-1:0] lane_rs3,
    output gpr_rsp_t                rsp
);

    word_t [NUM_THREADS-1:0] rs1_m;
    word_t [NUM_THREADS-1:0] rs2_m;
    word_t [NUM_THREADS-1:0] rs3_m;

    // Inactive lanes read back as zero
    always_comb begin
        for (int t = 0; t < NUM_THREADS; t++) begin
            rs1_m[t] = meta_tmask[t] ? lane_rs1[t] : '0;
            rs2_m[t] = meta_tmask[t] ? lane_rs2[t] : '0;
            rs3_m[t] = meta_tmask[t] ? lane_rs3[t] : '0;
        end
    end

    always_ff @(posedge clk) begin
        rsp.wid      <= meta_wid;
        rsp.rs1_data <= rs1_m;
        rsp.rs2_data <= rs2_m;
        rsp.rs3_data <= rs3_m;
        if (rst) begin
            rsp.valid <= 1'b0;
            rsp.tmask <= '0;
        end else begin
            rsp.valid <= meta_valid;
            rsp.tmask <= meta_tmask;
        end
    end

endmodule

`default_nettype wire

/* hw/gpr_file.sv */
`default_nettype none

module gpr_file
    import gpr_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  wb_req_t  wb,
    input  gpr_req_t req,
    output gpr_rsp_t rsp
);

    ram_addr_t               waddr;
    tmask_t                  lane_we;
    rd_addr_t                rd_addr;
    logic                    meta_valid;
    wid_t                    meta_wid;
    tmask_t                  meta_tmask;
    word_t [NUM_THREADS-1:0] lane_rs1;
    word_t [NUM_THREADS-1:0] lane_rs2;
    word_t [NUM_THREADS-1:0] lane_rs3;

    gpr_port_map port_map0 (
        .clk        (clk),
        .rst        (rst),
        .wb         (wb),
        .req        (req),
        .waddr      (waddr),
        .lane_we    (lane_we),
        .rd_addr    (rd_addr),
        .meta_valid (meta_valid),
        .meta_wid   (meta_wid),
        .meta_tmask (meta_tmask)
    );

    for (genvar t = 0; t < NUM_THREADS; t++) begin : g_lane
        gpr_lane lane0 (
            .clk      (clk),
            .we       (lane_we[t]),
            .waddr    (waddr),
            .wdata    (wb.data[t]),
            .rd_addr  (rd_addr),
            .rs1_data (lane_rs1[t]),
            .rs2_data (lane_rs2[t]),
            .rs3_data (lane_rs3[t])
        );
    end

    gpr_operand_collect collect0 (
        .clk        (clk),
        .rst        (rst),
        .meta_valid (meta_valid),
        .meta_wid   (meta_wid),
        .meta_tmask (meta_tmask),
        .lane_rs1   (lane_rs1),
        .lane_rs2   (lane_rs2),
        .lane_rs3   (lane_rs3),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

/* test/gpr_file_assert.sv */
`default_nettype none

module gpr_file_assert
    import gpr_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input wb_req_t  wb,
    input gpr_req_t req,
    input gpr_rsp_t rsp,
    input tmask_t   lane_we
);

    timeunit 1ns;
    timeprecision 100ps;

    // Every request gets its response after the fixed latency
    property p_req_to_rsp;
        @(posedge clk) disable iff (rst)
            req.valid |-> ##RSP_LATENCY rsp.valid;
    endproperty

    // And no response comes without a request
    property p_rsp_from_req;
        @(posedge clk) disable iff (rst)
            rsp.valid |-> $past(req.valid, RSP_LATENCY);
    endproperty

    property p_r0_no_write;
        @(posedge clk) (wb.rd == '0) |-> (lane_we == '0);
    endproperty

    property p_reset_clears_rsp;
        @(posedge clk) rst |=> !rsp.valid;
    endproperty

    a_req_to_rsp: assert property (p_req_to_rsp)
        else $error("Response missing %0d cycles after a request", RSP_LATENCY);

    a_rsp_from_req: assert property (p_rsp_from_req)
        else $error("Response without a request %0d cycles earlier", RSP_LATENCY);

    a_r0_no_write: assert property (p_r0_no_write)
        else $error("Lane write enable high for a writeback to r0");

    a_reset_clears_rsp: assert property (p_reset_clears_rsp)
        else $error("Response valid high in the cycle after reset");

endmodule

`default_nettype wire

/* test/gpr_file_tb.sv */
`default_nettype none

module gpr_file_tb
    import gpr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 5;
    localparam int IDLE_CYCLES    = 8;
    localparam int RAND_CYCLES    = 300;
    localparam int NUM_TESTS      = 5;
    localparam int TEST_OPS       = IDLE_CYCLES + NUM_WARPS * NUM_REGS
                                  + NUM_WARPS * 18 + NUM_WARPS * 3 + NUM_WARPS * 5
                                  + RAND_CYCLES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_OPS + NUM_TESTS * 8 + 100;
    localparam logic [15:0] MASK_SET = 16'hF35A;    // Partial and full thread masks

    logic     clk;
    logic     rst;
    wb_req_t  wb;
    gpr_req_t req;
    gpr_rsp_t rsp;

    word_t    ref_regs [NUM_WARPS][NUM_REGS][NUM_THREADS];
    gpr_rsp_t exp_q [$];
    int       exp_cyc_q [$];
    int       rd_idx     = 0;   // Next expected response
    int       neg_cnt    = 0;
    int       num_checks = 0;
    int       num_errors = 0;
    string    cur_test   = "reset";

    gpr_file dut0 (
        .clk (clk),
        .rst (rst),
        .wb  (wb),
        .req (req),
        .rsp (rsp)
    );

    bind gpr_file gpr_file_assert assert0 (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .req     (req),
        .rsp     (rsp),
        .lane_we (lane_we)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles in test %s", TIMEOUT_CYCLES, cur_test);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic int pick_mask(input int i);
        return int'(MASK_SET[(i % 4) * 4 +: 4]);
    endfunction

    function automatic wb_req_t make_wb(input int w, input int rd, input int m);
        wb_req_t x;
        x.valid = 1'b1;
        x.wid   = wid_t'(w);
        x.rd    = reg_idx_t'(rd);
        x.tmask = tmask_t'(m);
        for (int t = 0; t < NUM_THREADS; t++) begin
            x.data[t] = $urandom();
        end
        return x;
    endfunction

    function automatic gpr_req_t make_req(input int w, input int m, input int a, input int b,
                                          input int c);
        gpr_req_t x;
        x.valid = 1'b1;
        x.wid   = wid_t'(w);
        x.tmask = tmask_t'(m);
        x.rs1   = reg_idx_t'(a);
        x.rs2   = reg_idx_t'(b);
        x.rs3   = reg_idx_t'(c);
        return x;
    endfunction

    // r0 stays zero, unmasked lanes keep their value
    function automatic void update_model(input wb_req_t w);
        if (w.valid && w.rd != '0) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                if (w.tmask[t]) ref_regs[w.wid][w.rd][t] = w.data[t];
            end
        end
    endfunction

    function automatic gpr_rsp_t expected_rsp(input gpr_req_t r);
        gpr_rsp_t e;
        e       = '0;
        e.valid = 1'b1;
        e.wid   = r.wid;
        e.tmask = r.tmask;
        for (int t = 0; t < NUM_THREADS; t++) begin
            if (r.tmask[t]) begin
                e.rs1_data[t] = ref_regs[r.wid][r.rs1][t];
                e.rs2_data[t] = ref_regs[r.wid][r.rs2][t];
                e.rs3_data[t] = ref_regs[r.wid][r.rs3][t];
            end
        end
        return e;
    endfunction

    // One clock of stimulus; the write lands before the read sees the model
    task automatic drive_cycle(input wb_req_t w, input gpr_req_t r);
        @(posedge clk);
        wb  <= w;
        req <= r;
        update_model(w);
        if (r.valid) begin
            exp_q.push_back(expected_rsp(r));
            exp_cyc_q.push_back(neg_cnt + 1 + RSP_LATENCY);
        end
    endtask

    task automatic check_value(input string what, input word_t exp_v, input word_t act_v);
        num_checks++;
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
            num_errors++;
        end
    endtask

    task automatic compare_rsp(input gpr_rsp_t e, input int e_cyc);
        check_value("response cycle", word_t'(e_cyc), word_t'(neg_cnt));
        check_value("wid", word_t'(e.wid), word_t'(rsp.wid));
        check_value("tmask", word_t'(e.tmask), word_t'(rsp.tmask));
        for (int t = 0; t < NUM_THREADS; t++) begin
            check_value($sformatf("rs1 lane %0d", t), e.rs1_data[t], rsp.rs1_data[t]);
            check_value($sformatf("rs2 lane %0d", t), e.rs2_data[t], rsp.rs2_data[t]);
            check_value($sformatf("rs3 lane %0d", t), e.rs3_data[t], rsp.rs3_data[t]);
        end
    endtask

    // Responses are read where they are stable
    always @(negedge clk) begin
        neg_cnt = neg_cnt + 1;
        if (!rst && rsp.valid) begin
            assert (rd_idx < exp_q.size()) else begin
                $display("Response arrived in test %s with no request outstanding", cur_test);
                num_errors++;
            end
            if (rd_idx < exp_q.size()) begin
                compare_rsp(exp_q[rd_idx], exp_cyc_q[rd_idx]);
                rd_idx++;
            end
        end
    end

    task automatic finish_test(input int start_errs);
        drive_cycle('0, '0);
        while (rd_idx < exp_q.size()) @(negedge clk);
        repeat (RSP_LATENCY + 1) @(negedge clk);    // Room for a stray response
        @(posedge clk);
        $display("%-12s done: %0d errors", cur_test, num_errors - start_errs);
    endtask

    task automatic test_reset();
        int start_errs;
        start_errs = num_errors;
        cur_test = "reset";
        repeat (IDLE_CYCLES) drive_cycle('0, '0);
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                drive_cycle('0, make_req(w, 15, r, r + 1, r + 2));
            end
        end
        finish_test(start_errs);
    endtask

    task automatic test_write_read();
        int start_errs;
        start_errs = num_errors;
        cur_test = "write_read";
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 1; r <= 8; r++) begin
                drive_cycle(make_wb(w, r, pick_mask(r + w)), '0);
            end
        end
        // Reads reach past the written registers and mix in partial masks
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < 10; r++) begin
                drive_cycle('0, make_req(w, (r % 2 == 1) ? 15 : pick_mask(r), r, r + 1, r + 2));
            end
        end
        finish_test(start_errs);
    endtask

    task automatic test_r0_guard();
        int start_errs;
        start_errs = num_errors;
        cur_test = "r0_guard";
        for (int w = 0; w < NUM_WARPS; w++) begin
            drive_cycle(make_wb(w, 0, 15), '0);
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            drive_cycle('0, make_req(w, 15, 0, 0, 0));
            drive_cycle(make_wb(w, 0, 15), make_req(w, 15, 0, 0, 0));
        end
        finish_test(start_errs);
    endtask

    task automatic test_forward();
        int start_errs;
        int rd;
        start_errs = num_errors;
        cur_test = "forward";
        for (int w = 0; w < NUM_WARPS; w++) begin
            rd = 12 + w;
            drive_cycle(make_wb(w, rd, 15), '0);
            drive_cycle(make_wb(w, rd, 4'b0110), make_req(w, 15, rd, rd, rd + 1));
            drive_cycle(make_wb(w, rd + 1, 4'b1001), make_req(w, 15, rd - 1, rd, rd + 1));
            drive_cycle(make_wb(w, rd, 4'b1100), make_req(w, 4'b0101, rd, rd, rd));
            drive_cycle(make_wb(w + 1, rd, 15), make_req(w, 15, rd, rd, rd));  // Other warp
        end
        finish_test(start_errs);
    endtask

    task automatic test_random();
        int      start_errs;
        wb_req_t w;
        start_errs = num_errors;
        cur_test = "random";
        // Small register range so writes often hit the registers being read
        for (int i = 0; i < RAND_CYCLES; i++) begin
            w = make_wb($urandom_range(NUM_WARPS - 1), $urandom_range(7), $urandom_range(15));
            w.valid = ($urandom_range(1) == 1);
            drive_cycle(w, make_req($urandom_range(NUM_WARPS - 1), $urandom_range(15),
                                    $urandom_range(7), $urandom_range(7), $urandom_range(7)));
        end
        finish_test(start_errs);
    endtask

    initial begin
        void'($urandom(32'h5e));
        rst = 1'b1;
        wb  = '0;
        req = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                for (int t = 0; t < NUM_THREADS; t++) begin
                    ref_regs[w][r][t] = '0;
                end
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_reset();
        test_write_read();
        test_r0_guard();
        test_forward();
        test_random();

        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, num_checks,
                 num_errors);
        if (num_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gpr_file.f */
hw/gpr_pkg.sv
hw/gpr_dp_ram.sv
hw/gpr_port_map.sv
hw/gpr_lane.sv
hw/gpr_operand_collect.sv
hw/gpr_file.sv
test/gpr_file_assert.sv
test/gpr_file_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= gpr_file_tb
FILELIST  ?= gpr_file.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** PASSED ***

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
